//--- src/mem_bus_pkg.sv
`default_nettype none

// shared 16-bit pin bus between the PSRAM and the PCM
package mem_bus_pkg;

	// halfword address on the pins
	localparam int MEM_ADDR_W = 23;

	// data width of the shared bus
	localparam int MEM_DATA_W = 16;

	// one halfword location, word address plus half select in bit 0
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	typedef logic [MEM_DATA_W-1:0] mem_half_t;  // one bus transfer

endpackage

`default_nettype wire

//--- src/wb_pkg.sv
`default_nettype none

// classic wishbone slave port, 32-bit data, word addressed
package wb_pkg;

	localparam int WB_ADDR_W = 22;  // word address
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W  = WB_DATA_W / 8;  // one bit per byte lane

	typedef logic [WB_ADDR_W-1:0] wb_addr_t;
	typedef logic [WB_DATA_W-1:0] wb_data_t;
	typedef logic [WB_SEL_W-1:0]  wb_sel_t;

endpackage

`default_nettype wire

//--- src/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// one device controller towards the arbiter
interface mem_bus_if;
	import mem_bus_pkg::*;

	logic      req;    // wishbone cycle waiting for the bus
	logic      gnt;    // bus granted to this controller
	logic      busy;   // access in progress, selects the chip
	logic      oe_n;
	logic      we_n;
	logic      lb_n;
	logic      ub_n;
	mem_addr_t addr;
	mem_half_t wdata;
	mem_half_t rdata;  // straight from the pins

	modport ctrl (
		output req, busy, oe_n, we_n, lb_n, ub_n, addr, wdata,
		input  gnt, rdata
	);

	modport arb (
		input  req, busy, oe_n, we_n, lb_n, ub_n, addr, wdata,
		output gnt, rdata
	);

endinterface

`default_nettype wire

//--- src/psram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// one 32-bit wishbone access becomes two 16-bit psram accesses with the low half first
module psram_ctrl #(
	parameter int RAM_ACCESS_CYCLES = 3
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wb_cyc_i,
	input  logic             wb_stb_i,
	input  logic             wb_we_i,
	input  wb_pkg::wb_addr_t wb_addr_i,
	input  wb_pkg::wb_sel_t  wb_sel_i,
	input  wb_pkg::wb_data_t wb_data_i,
	output wb_pkg::wb_data_t wb_data_o,
	output logic             wb_ack_o,
	mem_bus_if.ctrl          bus
);
	import wb_pkg::*;

	localparam int CNT_W = (RAM_ACCESS_CYCLES > 1) ? $clog2(RAM_ACCESS_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RAM_ACCESS_CYCLES - 1);

	typedef enum logic [2:0] {S_IDLE, S_REQ, S_LOW, S_HIGH, S_ACK} psram_state_t;

	psram_state_t     state;
	logic [CNT_W-1:0] cnt;     // cycles spent in the current half
	logic             half;    // 1 while on data bits 31:16
	logic             active;
	logic             last;    // final cycle of a half
	wb_data_t         rd_q;

	assign half   = (state == S_HIGH);
	assign active = (state == S_LOW) || (state == S_HIGH);
	assign last   = active && (cnt == CNT_LAST);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (wb_cyc_i && wb_stb_i)
						state <= S_REQ;
				end
				S_REQ: begin
					cnt <= '0;
					if (bus.gnt)
						state <= S_LOW;
				end
				S_LOW, S_HIGH: begin
					if (last) begin
						cnt   <= '0;
						state <= half ? S_ACK : S_HIGH;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_ACK:   state <= S_IDLE;  // one-cycle ack
				default: state <= S_IDLE;
			endcase
		end
	end

	// read halves land in the last cycle of each half
	always_ff @(posedge clk) begin
		if (last && !wb_we_i) begin
			if (half)
				rd_q[31:16] <= bus.rdata;
			else
				rd_q[15:0] <= bus.rdata;
		end
	end

	assign bus.req   = (state == S_REQ);
	assign bus.busy  = active;
	assign bus.oe_n  = !(active && !wb_we_i);
	assign bus.we_n  = !(active && wb_we_i);
	assign bus.addr  = {wb_addr_i, half};
	assign bus.wdata = half ? wb_data_i[31:16] : wb_data_i[15:0];

	// byte lanes follow sel on writes and reads take the whole halfword
	always_comb begin
		bus.lb_n = 1'b1;
		bus.ub_n = 1'b1;
		if (active) begin
			if (wb_we_i) begin
				bus.lb_n = half ? !wb_sel_i[2] : !wb_sel_i[0];
				bus.ub_n = half ? !wb_sel_i[3] : !wb_sel_i[1];
			end else begin
				bus.lb_n = 1'b0;
				bus.ub_n = 1'b0;
			end
		end
	end

	assign wb_data_o = rd_q;
	assign wb_ack_o  = (state == S_ACK);

	// master must still hold the cycle when the ack comes back
	assert property (@(posedge clk) disable iff (rst) wb_ack_o |-> (wb_cyc_i && wb_stb_i))
		else $error("psram_ctrl: ack outside of a wishbone cycle");

	// address and strobes come straight from the master during an access
	assert property (@(posedge clk) disable iff (rst)
		active |-> ($stable(wb_addr_i) && $stable(wb_we_i) && $stable(wb_sel_i)))
		else $error("psram_ctrl: wishbone request changed during an access");

endmodule

`default_nettype wire

//--- src/pcm_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// wishbone to parallel pcm, reads and writes have their own access time
module pcm_ctrl #(
	parameter int PCM_READ_CYCLES  = 4,
	parameter int PCM_WRITE_CYCLES = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wb_cyc_i,
	input  logic             wb_stb_i,
	input  logic             wb_we_i,
	input  wb_pkg::wb_addr_t wb_addr_i,
	input  wb_pkg::wb_sel_t  wb_sel_i,
	input  wb_pkg::wb_data_t wb_data_i,
	output wb_pkg::wb_data_t wb_data_o,
	output logic             wb_ack_o,
	mem_bus_if.ctrl          bus
);
	import wb_pkg::*;

	localparam int MAX_CYC = (PCM_READ_CYCLES > PCM_WRITE_CYCLES) ?
		PCM_READ_CYCLES : PCM_WRITE_CYCLES;
	localparam int CNT_W = (MAX_CYC > 1) ? $clog2(MAX_CYC) : 1;
	localparam logic [CNT_W-1:0] RD_LAST = CNT_W'(PCM_READ_CYCLES - 1);
	localparam logic [CNT_W-1:0] WR_LAST = CNT_W'(PCM_WRITE_CYCLES - 1);

	typedef enum logic [2:0] {S_IDLE, S_REQ, S_LOW, S_HIGH, S_ACK} pcm_state_t;

	pcm_state_t       state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_last;  // depends on direction
	logic             half;
	logic             active;
	logic             last;
	logic             skip_lo;   // write with incomplete halfword sel
	logic             skip_hi;
	wb_data_t         rd_q;

	assign cnt_last = wb_we_i ? WR_LAST : RD_LAST;
	assign half     = (state == S_HIGH);
	assign active   = (state == S_LOW) || (state == S_HIGH);
	assign last     = active && (cnt == cnt_last);
	assign skip_lo  = wb_we_i && !(&wb_sel_i[1:0]);
	assign skip_hi  = wb_we_i && !(&wb_sel_i[3:2]);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (wb_cyc_i && wb_stb_i)
						state <= S_REQ;
				end
				S_REQ: begin
					cnt <= '0;
					if (bus.gnt) begin
						if (!skip_lo)
							state <= S_LOW;
						else if (!skip_hi)
							state <= S_HIGH;
						else
							state <= S_ACK;  // nothing to write
					end
				end
				S_LOW: begin
					if (last) begin
						cnt   <= '0;
						state <= skip_hi ? S_ACK : S_HIGH;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_HIGH: begin
					if (last) begin
						cnt   <= '0;
						state <= S_ACK;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= S_IDLE;  // ack lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (last && !wb_we_i) begin
			if (half)
				rd_q[31:16] <= bus.rdata;
			else
				rd_q[15:0] <= bus.rdata;
		end
	end

	assign bus.req   = (state == S_REQ);
	assign bus.busy  = active;
	assign bus.oe_n  = !(active && !wb_we_i);
	assign bus.we_n  = !(active && wb_we_i);
	assign bus.lb_n  = 1'b1;  // no byte strobes on the pcm
	assign bus.ub_n  = 1'b1;
	assign bus.addr  = {wb_addr_i, half};
	assign bus.wdata = half ? wb_data_i[31:16] : wb_data_i[15:0];

	assign wb_data_o = rd_q;
	assign wb_ack_o  = (state == S_ACK);

	// a partially selected halfword must never reach the array
	assert property (@(posedge clk) disable iff (rst)
		!bus.we_n |-> (half ? (&wb_sel_i[3:2]) : (&wb_sel_i[1:0])))
		else $error("pcm_ctrl: write strobe on a partially selected halfword");

endmodule

`default_nettype wire

//--- src/mem_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// one owner of the shared pins at a time with priority for the ram
module mem_bus_arbiter (
	input  logic                   clk,
	input  logic                   rst,
	mem_bus_if.arb                 ram,
	mem_bus_if.arb                 pcm,
	output logic                   ram_ce_n_o,
	output logic                   pcm_ce_n_o,
	output logic                   ram_lb_n_o,
	output logic                   ram_ub_n_o,
	output logic                   mem_oe_n_o,
	output logic                   mem_we_n_o,
	output mem_bus_pkg::mem_addr_t mem_addr_o,
	output mem_bus_pkg::mem_half_t mem_wdata_o,
	input  mem_bus_pkg::mem_half_t mem_rdata_i
);
	typedef enum logic [1:0] {OWN_NONE, OWN_RAM, OWN_PCM} owner_t;

	owner_t owner;
	logic   any_busy;
	logic   hold;  // owner is starting or running an access

	assign any_busy = ram.busy || pcm.busy;
	// keep the grant from the cycle a controller sees gnt until its access ends
	assign hold = ((owner == OWN_RAM) && ram.req) || ((owner == OWN_PCM) && pcm.req);

	always_ff @(posedge clk) begin
		if (rst) begin
			owner <= OWN_NONE;
		end else if (!any_busy && !hold) begin
			if (ram.req)
				owner <= OWN_RAM;
			else if (pcm.req)
				owner <= OWN_PCM;
			else
				owner <= OWN_NONE;
		end
	end

	assign ram.gnt = (owner == OWN_RAM);
	assign pcm.gnt = (owner == OWN_PCM);

	assign ram.rdata = mem_rdata_i;
	assign pcm.rdata = mem_rdata_i;

	assign ram_ce_n_o = !ram.busy;
	assign pcm_ce_n_o = !pcm.busy;

	// pins idle high with a zero address when nobody drives them
	always_comb begin
		ram_lb_n_o  = 1'b1;
		ram_ub_n_o  = 1'b1;
		mem_oe_n_o  = 1'b1;
		mem_we_n_o  = 1'b1;
		mem_addr_o  = '0;
		mem_wdata_o = '0;
		if (ram.busy) begin
			ram_lb_n_o  = ram.lb_n;
			ram_ub_n_o  = ram.ub_n;
			mem_oe_n_o  = ram.oe_n;
			mem_we_n_o  = ram.we_n;
			mem_addr_o  = ram.addr;
			mem_wdata_o = ram.wdata;
		end else if (pcm.busy) begin
			ram_lb_n_o  = pcm.lb_n;  // held high by the pcm side
			ram_ub_n_o  = pcm.ub_n;
			mem_oe_n_o  = pcm.oe_n;
			mem_we_n_o  = pcm.we_n;
			mem_addr_o  = pcm.addr;
			mem_wdata_o = pcm.wdata;
		end
	end

	// a controller only drives the pins while it holds the grant
	assert property (@(posedge clk) disable iff (rst)
		(!ram.busy || ram.gnt) && (!pcm.busy || pcm.gnt))
		else $error("mem_bus_arbiter: access running without a grant");

	// both controllers driving at once would short the shared pins
	assert property (@(posedge clk) disable iff (rst) !(ram.busy && pcm.busy))
		else $error("mem_bus_arbiter: both controllers busy");

endmodule

`default_nettype wire

//--- src/wb_memory_top.sv
`timescale 1ns/1ps
`default_nettype none

// psram and pcm behind two wishbone slaves, sharing one pin bus
module wb_memory_top #(
	parameter int RAM_ACCESS_CYCLES = 3,
	parameter int PCM_READ_CYCLES   = 4,
	parameter int PCM_WRITE_CYCLES  = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	// ram slave
	input  logic                   ram_cyc_i,
	input  logic                   ram_stb_i,
	input  logic                   ram_we_i,
	input  wb_pkg::wb_addr_t       ram_addr_i,
	input  wb_pkg::wb_sel_t        ram_sel_i,
	input  wb_pkg::wb_data_t       ram_data_i,
	output wb_pkg::wb_data_t       ram_data_o,
	output logic                   ram_ack_o,
	// pcm slave
	input  logic                   pcm_cyc_i,
	input  logic                   pcm_stb_i,
	input  logic                   pcm_we_i,
	input  wb_pkg::wb_addr_t       pcm_addr_i,
	input  wb_pkg::wb_sel_t        pcm_sel_i,
	input  wb_pkg::wb_data_t       pcm_data_i,
	output wb_pkg::wb_data_t       pcm_data_o,
	output logic                   pcm_ack_o,
	// shared pins, mem_oe_n_o gives the data direction
	output logic                   ram_ce_n_o,
	output logic                   pcm_ce_n_o,
	output logic                   ram_lb_n_o,
	output logic                   ram_ub_n_o,
	output logic                   mem_oe_n_o,
	output logic                   mem_we_n_o,
	output mem_bus_pkg::mem_addr_t mem_addr_o,
	output mem_bus_pkg::mem_half_t mem_wdata_o,
	input  mem_bus_pkg::mem_half_t mem_rdata_i
);
	mem_bus_if ram_bus ();
	mem_bus_if pcm_bus ();

	psram_ctrl #(
		.RAM_ACCESS_CYCLES(RAM_ACCESS_CYCLES)
	) i_psram (
		.clk       (clk),
		.rst       (rst),
		.wb_cyc_i  (ram_cyc_i),
		.wb_stb_i  (ram_stb_i),
		.wb_we_i   (ram_we_i),
		.wb_addr_i (ram_addr_i),
		.wb_sel_i  (ram_sel_i),
		.wb_data_i (ram_data_i),
		.wb_data_o (ram_data_o),
		.wb_ack_o  (ram_ack_o),
		.bus       (ram_bus.ctrl)
	);

	pcm_ctrl #(
		.PCM_READ_CYCLES (PCM_READ_CYCLES),
		.PCM_WRITE_CYCLES(PCM_WRITE_CYCLES)
	) i_pcm (
		.clk       (clk),
		.rst       (rst),
		.wb_cyc_i  (pcm_cyc_i),
		.wb_stb_i  (pcm_stb_i),
		.wb_we_i   (pcm_we_i),
		.wb_addr_i (pcm_addr_i),
		.wb_sel_i  (pcm_sel_i),
		.wb_data_i (pcm_data_i),
		.wb_data_o (pcm_data_o),
		.wb_ack_o  (pcm_ack_o),
		.bus       (pcm_bus.ctrl)
	);

	mem_bus_arbiter i_arbiter (
		.clk         (clk),
		.rst         (rst),
		.ram         (ram_bus.arb),
		.pcm         (pcm_bus.arb),
		.ram_ce_n_o  (ram_ce_n_o),
		.pcm_ce_n_o  (pcm_ce_n_o),
		.ram_lb_n_o  (ram_lb_n_o),
		.ram_ub_n_o  (ram_ub_n_o),
		.mem_oe_n_o  (mem_oe_n_o),
		.mem_we_n_o  (mem_we_n_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_rdata_i (mem_rdata_i)
	);

endmodule

`default_nettype wire

//--- verification/mem_device_model.sv
`timescale 1ns/1ps
`default_nettype none

// behavioural psram and pcm arrays hanging on the shared pins
module mem_device_model (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ram_ce_n_i,
	input  logic                   pcm_ce_n_i,
	input  logic                   lb_n_i,
	input  logic                   ub_n_i,
	input  logic                   oe_n_i,
	input  logic                   we_n_i,
	input  mem_bus_pkg::mem_addr_t addr_i,
	input  mem_bus_pkg::mem_half_t wdata_i,
	output mem_bus_pkg::mem_half_t rdata_o,
	output logic                   error_o
);
	import mem_bus_pkg::*;

	mem_half_t ram_mem [mem_addr_t];  // sparse, indexed by halfword address
	mem_half_t pcm_mem [mem_addr_t];

	// content of a location never written
	function automatic mem_half_t fill(input mem_addr_t a);
		return a[15:0] ^ {a[22:16], a[22:14]};
	endfunction

	always_comb begin
		rdata_o = '0;
		if (!oe_n_i && !ram_ce_n_i)
			rdata_o = ram_mem.exists(addr_i) ? ram_mem[addr_i] : fill(addr_i);
		else if (!oe_n_i && !pcm_ce_n_i)
			rdata_o = pcm_mem.exists(addr_i) ? pcm_mem[addr_i] : ~fill(addr_i);
	end

	always @(posedge clk) begin : write_port
		mem_half_t cur;
		if (!we_n_i && !ram_ce_n_i) begin
			cur = ram_mem.exists(addr_i) ? ram_mem[addr_i] : fill(addr_i);
			if (!lb_n_i)
				cur[7:0] = wdata_i[7:0];
			if (!ub_n_i)
				cur[15:8] = wdata_i[15:8];
			ram_mem[addr_i] = cur;
		end
		if (!we_n_i && !pcm_ce_n_i)
			pcm_mem[addr_i] = wdata_i;  // pcm always takes the whole halfword
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			error_o <= 1'b0;
		end else begin
			if (!ram_ce_n_i && !pcm_ce_n_i) begin
				$display("model: both chip enables low, address %h", addr_i);
				error_o <= 1'b1;
			end
			if ((!ram_ce_n_i || !pcm_ce_n_i) && !oe_n_i && !we_n_i) begin
				$display("model: oe_n and we_n low together, address %h", addr_i);
				error_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/tb_wb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_memory;
	import mem_bus_pkg::*;
	import wb_pkg::*;

	localparam int RAM_ACCESS_CYCLES = 3;
	localparam int PCM_READ_CYCLES   = 4;
	localparam int PCM_WRITE_CYCLES  = 8;
	localparam int N_ACCESS          = 24;  // wishbone accesses over all tests
	localparam int TIMEOUT_NS = N_ACCESS * (2 * PCM_WRITE_CYCLES + 2 * RAM_ACCESS_CYCLES + 4) * 10
		+ 1000;

	logic      clk;
	logic      rst;
	logic      ram_cyc, ram_stb, ram_we, ram_ack;
	logic      pcm_cyc, pcm_stb, pcm_we, pcm_ack;
	wb_addr_t  ram_addr, pcm_addr;
	wb_sel_t   ram_sel, pcm_sel;
	wb_data_t  ram_wdata, ram_rdata, pcm_wdata, pcm_rdata;
	logic      ram_ce_n, pcm_ce_n, ram_lb_n, ram_ub_n, mem_oe_n, mem_we_n;
	mem_addr_t mem_addr;
	mem_half_t mem_wdata, mem_rdata;
	logic      model_err;
	int        cycle_cnt = 0;  // rising edges since start

	wb_data_t  ram_exp [wb_addr_t];  // expected word per address
	wb_data_t  pcm_exp [wb_addr_t];

	wb_memory_top #(
		.RAM_ACCESS_CYCLES(RAM_ACCESS_CYCLES),
		.PCM_READ_CYCLES  (PCM_READ_CYCLES),
		.PCM_WRITE_CYCLES (PCM_WRITE_CYCLES)
	) i_dut (
		.clk(clk), .rst(rst),
		.ram_cyc_i(ram_cyc), .ram_stb_i(ram_stb), .ram_we_i(ram_we),
		.ram_addr_i(ram_addr), .ram_sel_i(ram_sel), .ram_data_i(ram_wdata),
		.ram_data_o(ram_rdata), .ram_ack_o(ram_ack),
		.pcm_cyc_i(pcm_cyc), .pcm_stb_i(pcm_stb), .pcm_we_i(pcm_we),
		.pcm_addr_i(pcm_addr), .pcm_sel_i(pcm_sel), .pcm_data_i(pcm_wdata),
		.pcm_data_o(pcm_rdata), .pcm_ack_o(pcm_ack),
		.ram_ce_n_o(ram_ce_n), .pcm_ce_n_o(pcm_ce_n),
		.ram_lb_n_o(ram_lb_n), .ram_ub_n_o(ram_ub_n),
		.mem_oe_n_o(mem_oe_n), .mem_we_n_o(mem_we_n),
		.mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata)
	);

	mem_device_model i_model (
		.clk(clk), .rst(rst),
		.ram_ce_n_i(ram_ce_n), .pcm_ce_n_i(pcm_ce_n),
		.lb_n_i(ram_lb_n), .ub_n_i(ram_ub_n),
		.oe_n_i(mem_oe_n), .we_n_i(mem_we_n),
		.addr_i(mem_addr), .wdata_i(mem_wdata), .rdata_o(mem_rdata),
		.error_o(model_err)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	task automatic fail_run();
		$display("test failed");
		$fatal(1);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired, the DUT stopped answering");
		fail_run();
	end

	always @(negedge clk) begin
		if (model_err) begin
			$display("memory model reported a conflict on the shared pins");
			fail_run();
		end
	end

	task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			fail_run();
		end
	endtask

	// byte lanes of new_w replace old_w where sel is set
	function automatic wb_data_t merge_bytes(input wb_data_t old_w, input wb_data_t new_w,
		input wb_sel_t sel);
		wb_data_t res;
		res = old_w;
		for (int i = 0; i < 4; i++)
			if (sel[i])
				res[8*i +: 8] = new_w[8*i +: 8];
		return res;
	endfunction

	// pcm only writes halfwords with both bytes selected
	function automatic wb_data_t merge_halves(input wb_data_t old_w, input wb_data_t new_w,
		input wb_sel_t sel);
		wb_data_t res;
		res = old_w;
		for (int h = 0; h < 2; h++)
			if (&sel[2*h +: 2])
				res[16*h +: 16] = new_w[16*h +: 16];
		return res;
	endfunction

	task automatic drive_port(input bit to_pcm, input logic cyc, input logic we,
		input wb_addr_t addr, input wb_sel_t sel, input wb_data_t data);
		if (to_pcm) begin
			pcm_cyc   = cyc;
			pcm_stb   = cyc;
			pcm_we    = we;
			pcm_addr  = addr;
			pcm_sel   = sel;
			pcm_wdata = data;
		end else begin
			ram_cyc   = cyc;
			ram_stb   = cyc;
			ram_we    = we;
			ram_addr  = addr;
			ram_sel   = sel;
			ram_wdata = data;
		end
	endtask

	// one classic cycle, held until ack; ack_at is the cycle the ack was seen
	task automatic wb_access(input bit to_pcm, input logic we, input wb_addr_t addr,
		input wb_sel_t sel, input wb_data_t wdata, output wb_data_t rdata, output int ack_at);
		@(negedge clk);
		drive_port(to_pcm, 1'b1, we, addr, sel, wdata);
		do
			@(negedge clk);
		while (!(to_pcm ? pcm_ack : ram_ack));
		rdata  = to_pcm ? pcm_rdata : ram_rdata;
		ack_at = cycle_cnt;
		@(negedge clk);  // release after the edge that ends the ack
		drive_port(to_pcm, 1'b0, 1'b0, '0, '0, '0);
	endtask

	task automatic wb_write(input bit to_pcm, input wb_addr_t addr, input wb_sel_t sel,
		input wb_data_t data, output int ack_at);
		wb_data_t unused;
		wb_access(to_pcm, 1'b1, addr, sel, data, unused, ack_at);
	endtask

	task automatic wb_read(input bit to_pcm, input wb_addr_t addr, output wb_data_t data);
		int ack_at;
		wb_access(to_pcm, 1'b0, addr, 4'hf, '0, data, ack_at);
	endtask

	task automatic reset_and_latency();
		wb_addr_t a;
		wb_data_t d;
		int       first;
		int       ack_at;
		check_level("ram_ack_o", ram_ack, 1'b0);
		check_level("pcm_ack_o", pcm_ack, 1'b0);
		check_level("mem_oe_n_o", mem_oe_n, 1'b1);
		check_level("mem_we_n_o", mem_we_n, 1'b1);
		check_level("ram_ce_n_o", ram_ce_n, 1'b1);
		check_level("pcm_ce_n_o", pcm_ce_n, 1'b1);
		a = wb_addr_t'($urandom);
		d = $urandom;
		fork
			wb_write(1'b0, a, 4'hf, d, ack_at);
			begin
				while (ram_ce_n)
					@(negedge clk);
				first = cycle_cnt;
				check_addr("mem_addr_o", mem_addr, {a, 1'b0});  // low half first
			end
		join
		ram_exp[a] = d;
		check_count("ram ack latency", ack_at - first + 1, 2 * RAM_ACCESS_CYCLES + 1);
	endtask

	task automatic ram_round_trip();
		wb_addr_t addrs [4];
		wb_data_t d;
		int       ack_at;
		for (int i = 0; i < 4; i++) begin
			addrs[i] = wb_addr_t'($urandom);
			d = $urandom;
			wb_write(1'b0, addrs[i], 4'hf, d, ack_at);
			ram_exp[addrs[i]] = d;
		end
		for (int i = 0; i < 4; i++) begin
			wb_read(1'b0, addrs[i], d);
			check_data("ram_data_o", d, ram_exp[addrs[i]]);
		end
	endtask

	task automatic ram_byte_lanes();
		wb_sel_t  sels [2] = '{4'b0110, 4'b1001};
		wb_addr_t a;
		wb_data_t d;
		int       ack_at;
		a = wb_addr_t'($urandom);
		d = $urandom;
		wb_write(1'b0, a, 4'hf, d, ack_at);
		ram_exp[a] = d;
		foreach (sels[i]) begin
			d = $urandom;
			wb_write(1'b0, a, sels[i], d, ack_at);
			ram_exp[a] = merge_bytes(ram_exp[a], d, sels[i]);
			wb_read(1'b0, a, d);
			check_data("ram_data_o", d, ram_exp[a]);
		end
	endtask

	task automatic pcm_round_trip();
		wb_sel_t  sels [2] = '{4'b1101, 4'b0110};  // second one writes nothing
		wb_addr_t a;
		wb_data_t d;
		int       ack_at;
		a = wb_addr_t'($urandom);
		d = $urandom;
		wb_write(1'b1, a, 4'hf, d, ack_at);
		pcm_exp[a] = d;
		wb_read(1'b1, a, d);
		check_data("pcm_data_o", d, pcm_exp[a]);
		foreach (sels[i]) begin
			d = $urandom;
			wb_write(1'b1, a, sels[i], d, ack_at);
			pcm_exp[a] = merge_halves(pcm_exp[a], d, sels[i]);
			wb_read(1'b1, a, d);
			check_data("pcm_data_o", d, pcm_exp[a]);
		end
	endtask

	task automatic contention();
		wb_addr_t ar, ap;
		wb_data_t dr, dp, got;
		int       ack_r, ack_p;
		ar = wb_addr_t'($urandom);
		ap = wb_addr_t'($urandom);
		dr = $urandom;
		dp = $urandom;
		fork
			wb_write(1'b0, ar, 4'hf, dr, ack_r);
			wb_write(1'b1, ap, 4'hf, dp, ack_p);
		join
		ram_exp[ar] = dr;
		pcm_exp[ap] = dp;
		if (ack_r >= ack_p) begin
			$display("ram ack came at cycle %0d, not before pcm ack at %0d", ack_r, ack_p);
			fail_run();
		end
		wb_read(1'b0, ar, got);
		check_data("ram_data_o", got, ram_exp[ar]);
		wb_read(1'b1, ap, got);
		check_data("pcm_data_o", got, pcm_exp[ap]);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		drive_port(1'b0, 1'b0, 1'b0, '0, '0, '0);
		drive_port(1'b1, 1'b0, 1'b0, '0, '0, '0);
		void'($urandom(32'hf539));
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		reset_and_latency();
		ram_round_trip();
		ram_byte_lanes();
		pcm_round_trip();
		contention();
		@(negedge clk);
		if (model_err) begin
			$display("memory model reported a conflict on the shared pins");
			fail_run();
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tb.f
src/mem_bus_pkg.sv
src/wb_pkg.sv
src/mem_bus_if.sv
src/psram_ctrl.sv
src/pcm_ctrl.sv
src/mem_bus_arbiter.sv
src/wb_memory_top.sv
verification/mem_device_model.sv
verification/tb_wb_memory.sv

//--- Makefile
# Verilator build and run of the shared memory testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_memory
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the result is taken from the pass line on stdout, not from the exit code
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
